// ==== bench/fetch_unit_stim.txt ====
// program image as 64 bit words in hex, upper half holds the odd word address
// records at @40: start_pc credit_mode(0 prompt 1 starved 2 random) stall_pct mid_cycle mid_pc count
// the first record runs straight out of reset from pc 0 and uses no start redirect

@00
00208093_00108093  // 000 addi x1,x1,1 and 004 addi x1,x1,2
00408093_00308093  // 008 and 00c where the odd word start begins
00608093_00508093  // 010
00808093_00708093  // 018
00908093_0200006f  // 020 jal x0,+0x20 in slot 0 so 024 is killed
00b08093_00a08093  // 028 never reached
@08
01c0006f_00c08093  // 040 plain then 044 jal x0,+0x1c in slot 1
00e08093_00d08093  // 048 skipped by the jal
@0c
00f08093_00000863  // 060 beq x0,x0,+0x10 forward so it falls through to 064
f8000ae3_01008093  // 068 plain then 06c beq x0,x0,-0x6c back to 000
@20
01208093_01108093  // 100 second loop used as a redirect target
01408093_01308093  // 108
01508093_fe0008e3  // 110 beq x0,x0,-0x10 back to 100 so 114 is killed

@40
0   0 00 00 0   14  // reset start, prompt credits
c   0 00 00 0   14  // odd word start drops slot 0
40  1 00 00 0   10  // starved credits through jal in slot 1 and both branches
0   2 1e 00 0   28  // random credits with memory stalls
0   0 14 0c 104 14  // mid run redirect into the second loop
60  2 0a 07 c   18  // random credits and a mid run redirect to an odd word
100 1 19 00 0   10  // starved credits with stalls on the short loop
0   0 00 00 0   00  // end of records

// ==== bench/fetch_unit_tb.sv ====
// fetch unit testbench with a memory model, a credit returning decode model and a reference walker
module fetch_unit_tb;
  import fetch_pkg::*;

  localparam int image_words = 64;    // program occupies word index 0 .. 63
  localparam int record_base = 'h40;  // test records follow the image
  localparam int record_size = 6;
  localparam int stim_words  = 256;

  logic                  clock;
  logic                  reset;
  logic [xlen-1:0]       imem_data;
  logic                  imem_valid;
  logic                  redirect_valid;
  logic [xlen-1:0]       redirect_pc;
  logic                  dec_credit;
  logic [xlen-1:0]       imem_addr;
  logic                  dec_valid;
  logic [xlen-1:0]       dec_pc;
  logic [inst_width-1:0] dec_inst;
  logic [xlen-1:0]       dec_pred_next;

  logic [63:0]     stim [stim_words];  // image and records as loaded
  int              errors;             // failed checks over the whole run
  int              n_tests;
  longint          total_expected;
  longint          watchdog_limit;
  bit              watch_ready;

  // current test record
  logic [xlen-1:0] start_pc;
  int              credit_mode;        // 0 prompt, 1 starved, 2 random
  int              stall_pct;          // chance of a memory miss per cycle
  int              mid_cycle;          // 0 when there is no mid-run redirect
  logic [xlen-1:0] mid_pc;
  int              expect_count;
  bit              from_reset;         // first test starts at pc 0 without a redirect

  // reference walker and decode model
  logic [xlen-1:0] walk_pc;            // pc the stream must deliver next
  int              got;                // checked since the last redirect
  bit              mid_done;
  bit              expect_idle;        // dec_valid must be low this cycle
  int              outstanding;        // entries held in decode's buffer
  bit              credit_pending;     // pulse that lands on the coming edge

  fetch_unit fetch_unit_inst (
    .clock          (clock),
    .reset          (reset),
    .imem_data      (imem_data),
    .imem_valid     (imem_valid),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .dec_credit     (dec_credit),
    .imem_addr      (imem_addr),
    .dec_valid      (dec_valid),
    .dec_pc         (dec_pc),
    .dec_inst       (dec_inst),
    .dec_pred_next  (dec_pred_next)
  );

  always #20 clock = ~clock;  // period 40

  //////////////////////////////////////////////////////////////////////
  // memory and reference model
  //////////////////////////////////////////////////////////////////////

  // two addi x1,x0,imm with every address bit folded into the immediate
  function automatic logic [63:0] fill_word(logic [xlen-1:0] addr);
    logic [11:0] imm;
    imm = 12'((addr >> 3) % 64'd4093);
    fill_word = {imm ^ 12'hfff, 20'h00093, imm, 20'h00093};
  endfunction

  function automatic logic [63:0] mem_word(logic [xlen-1:0] addr);
    if (addr < xlen'(image_words * 8))
      mem_word = stim[addr[8:3]];
    else
      mem_word = fill_word(addr);  // outside the image
  endfunction

  function automatic logic [inst_width-1:0] inst_at(logic [xlen-1:0] pc);
    logic [63:0] word;
    word = mem_word({pc[xlen-1:3], 3'b000});
    inst_at = pc[2] ? word[63:32] : word[31:0];  // upper half is the odd word
  endfunction

  // static rule with jal taken, backward branch taken and all else falling through
  function automatic logic [xlen-1:0] predict_next(logic [xlen-1:0] pc,
                                                   logic [inst_width-1:0] inst);
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] imm_b;
    imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    if (inst[6:0] == 7'b1101111)
      predict_next = pc + imm_j;                     // jal
    else if (inst[6:0] == 7'b1100011 && inst[31])
      predict_next = pc + imm_b;                     // backward branch
    else
      predict_next = pc + 64'd4;
  endfunction

  task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
    if (actual !== expected)
    begin
      $display("FAIL %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // per cycle work at the falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic observe();
    logic [inst_width-1:0] exp_inst;
    logic [xlen-1:0]       exp_next;
    if (expect_idle)
    begin
      check_value("dec_valid", 64'd0, 64'(dec_valid));  // cycle after reset or redirect
      expect_idle = 1'b0;
    end
    else if (dec_valid)
    begin
      if (outstanding >= decode_credits)
      begin
        $display("dec_valid rose at time %0t with no credit left in the decode model", $time);
        errors++;
      end
      exp_inst = inst_at(walk_pc);
      exp_next = predict_next(walk_pc, exp_inst);
      check_value("dec_pc", walk_pc, dec_pc);
      check_value("dec_inst", 64'(exp_inst), 64'(dec_inst));
      check_value("dec_pred_next", exp_next, dec_pred_next);
      walk_pc = exp_next;
      got++;
    end
    if (dec_valid)
      outstanding++;       // decode buffers the delivery
    if (credit_pending)
    begin
      outstanding--;       // last pulse was counted at the edge just passed
      credit_pending = 1'b0;
    end
  endtask

  task automatic drive(int cycle);
    bit give;
    check_value("imem_addr[2:0]", 64'd0, 64'(imem_addr[2:0]));  // whole words only
    imem_data      = mem_word(imem_addr);  // address holds until the next edge
    imem_valid     = ($urandom % 100) >= stall_pct;
    redirect_valid = 1'b0;
    if ((cycle == 0 && !from_reset) || (mid_cycle != 0 && cycle == mid_cycle))
    begin
      redirect_valid = 1'b1;
      redirect_pc    = (cycle == 0) ? start_pc : mid_pc;
      walk_pc        = redirect_pc;        // older fetches must never appear
      got            = 0;
      expect_idle    = 1'b1;
      mid_done       = mid_done || (cycle != 0);
    end
    case (credit_mode)
      0:       give = outstanding > 0;                          // prompt
      1:       give = outstanding > 0 && (cycle % 6) == 5;      // starved
      default: give = outstanding > 0 && ($urandom % 2) == 1;   // random
    endcase
    dec_credit     = give;
    credit_pending = give;
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    int passed;
    int failed;
    int errors_before;
    int cycle;
    int base;
    clock          = 1'b0;
    reset          = 1'b1;
    imem_data      = '0;
    imem_valid     = 1'b0;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    dec_credit     = 1'b0;
    passed         = 0;
    failed         = 0;
    void'($urandom(24750));
    for (int i = 0; i < stim_words; i++)
      stim[i] = (i < image_words) ? fill_word(64'(i) << 3) : 64'd0;
    $readmemh("bench/fetch_unit_stim.txt", stim);

    // records end at the first zero count
    n_tests        = 0;
    total_expected = 0;
    while (record_base + (n_tests + 1) * record_size <= stim_words &&
           stim[record_base + n_tests * record_size + 5] != 0)
    begin
      total_expected += stim[record_base + n_tests * record_size + 5];
      n_tests++;
    end
    watchdog_limit = (total_expected * 40 + 400) * 40;
    watch_ready    = 1'b1;

    repeat (3) @(posedge clock);
    @(negedge clock);
    reset       = 1'b0;
    walk_pc     = '0;   // fetch restarts at address 0
    expect_idle = 1'b1;

    for (int t = 0; t < n_tests; t++)
    begin
      base          = record_base + t * record_size;
      start_pc      = stim[base];
      credit_mode   = int'(stim[base + 1]);
      stall_pct     = int'(stim[base + 2]);
      mid_cycle     = int'(stim[base + 3]);
      mid_pc        = stim[base + 4];
      expect_count  = int'(stim[base + 5]);
      from_reset    = (t == 0);
      mid_done      = (mid_cycle == 0);
      got           = 0;
      cycle         = 0;
      errors_before = errors;
      do
      begin
        @(negedge clock);
        observe();
        drive(cycle);
        cycle++;
      end while (got < expect_count || !mid_done);
      if (errors == errors_before)
      begin
        passed++;
        $display("test %0d ok: start %h credit mode %0d stall %0d%%", t, start_pc,
                 credit_mode, stall_pct);
      end
      else
      begin
        failed++;
        $display("test %0d failed with %0d errors", t, errors - errors_before);
      end
    end

    $display("tests passed %0d failed %0d", passed, failed);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  // ends a run whose instruction stream stops flowing
  initial
  begin
    wait (watch_ready);
    #(watchdog_limit);
    $display("timeout: the instruction stream stalled before all tests finished");
    $display("Finished with errors");
    $finish;
  end

endmodule

// ==== compile.f ====
logic/fetch_pkg.sv
logic/fetch_stage.sv
logic/bundle_predecode.sv
logic/fetch_queue.sv
logic/fetch_unit.sv
bench/fetch_unit_tb.sv

// ==== logic/bundle_predecode.sv ====
// bundle predecoder that finds jumps and branches and predicts the first taken slot statically
module bundle_predecode (
  input  logic [fetch_pkg::fetch_width-1:0][fetch_pkg::inst_width-1:0] slot_inst,
  input  logic [fetch_pkg::fetch_width-1:0][fetch_pkg::xlen-1:0]       slot_pc,
  input  logic [fetch_pkg::fetch_width-1:0]                            slot_fetched,
  output logic [fetch_pkg::fetch_width-1:0]                            slot_valid,
  output logic [fetch_pkg::fetch_width-1:0][fetch_pkg::xlen-1:0]       slot_next,
  output logic                                                         pred_taken,
  output logic [fetch_pkg::xlen-1:0]                                   pred_target
);
  import fetch_pkg::*;

  opcode_e                slot_op    [fetch_width];  // raw major opcode
  inst_kind_e             slot_kind  [fetch_width];
  logic [xlen-1:0]        imm_j      [fetch_width];  // sign extended jal offset
  logic [xlen-1:0]        imm_b      [fetch_width];  // sign extended branch offset
  logic [xlen-1:0]        target     [fetch_width];  // pc relative target
  logic [fetch_width-1:0] slot_taken;                // predicted taken if it survives

  //////////////////////////////////////////////////////////////////////
  // per slot classification and target
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int s = 0; s < fetch_width; s++)
    begin
      slot_op[s] = opcode_e'(slot_inst[s][6:0]);

      case (slot_op[s])
        op_jal:    slot_kind[s] = kind_jump;
        op_branch: slot_kind[s] = kind_branch;
        op_jalr:   slot_kind[s] = kind_plain;  // register target, left to execute
        default:   slot_kind[s] = kind_plain;
      endcase

      // J type offset, bit 31 is the sign
      imm_j[s] = {{(xlen - 20){slot_inst[s][31]}},
                  slot_inst[s][19:12],
                  slot_inst[s][20],
                  slot_inst[s][30:21],
                  1'b0};

      // B type offset, bit 31 is the sign
      imm_b[s] = {{(xlen - 12){slot_inst[s][31]}},
                  slot_inst[s][7],
                  slot_inst[s][30:25],
                  slot_inst[s][11:8],
                  1'b0};

      if (slot_kind[s] == kind_jump)
        target[s] = slot_pc[s] + imm_j[s];
      else
        target[s] = slot_pc[s] + imm_b[s];  // meaningless for plain slots

      // static rule, jal always, branch only backward
      slot_taken[s] = (slot_kind[s] == kind_jump) ||
                      ((slot_kind[s] == kind_branch) && slot_inst[s][31]);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // first taken slot
  //////////////////////////////////////////////////////////////////////

  // walk slots oldest first; once one is taken the younger ones die
  always_comb
  begin
    pred_taken  = 1'b0;
    pred_target = '0;  // only looked at with pred_taken
    for (int s = 0; s < fetch_width; s++)
    begin
      slot_valid[s] = slot_fetched[s] && !pred_taken;

      // next pc that execute will check this slot against
      if (slot_taken[s])
        slot_next[s] = target[s];
      else
        slot_next[s] = slot_pc[s] + xlen'(4);

      if (slot_valid[s] && slot_taken[s])
      begin
        pred_taken  = 1'b1;
        pred_target = target[s];
      end
    end
  end

endmodule

// ==== logic/fetch_pkg.sv ====
// fetch front end package with datapath widths, queue sizing, the nop encoding and predecode enums
package fetch_pkg;

  //////////////////////////////////////////////////////////////////////
  // datapath widths
  //////////////////////////////////////////////////////////////////////

  localparam int xlen        = 64;  // pc and memory word width
  localparam int inst_width  = 32;  // one uncompressed instruction
  localparam int fetch_width = 2;   // slots per fetched bundle

  //////////////////////////////////////////////////////////////////////
  // queue and credit sizing
  //////////////////////////////////////////////////////////////////////

  localparam int queue_depth    = 8;  // keep a power of two so pointers wrap naturally
  localparam int decode_credits = 4;  // matches the decode input buffer

  // derived counter widths
  localparam int qptr_width     = $clog2(queue_depth);
  localparam int count_width    = $clog2(queue_depth + 1);     // holds 0 .. queue_depth
  localparam int credit_width   = $clog2(decode_credits + 1);  // holds 0 .. decode_credits
  localparam int slot_cnt_width = $clog2(fetch_width + 1);     // valid slots in one bundle

  // filler for slots that were not fetched
  localparam logic [inst_width-1:0] nop_inst = 32'h0000_0013;  // addi x0, x0, 0

  //////////////////////////////////////////////////////////////////////
  // predecode encodings
  //////////////////////////////////////////////////////////////////////

  // major opcodes that matter to the predictor
  typedef enum logic [6:0] {
    op_branch = 7'b110_0011,  // conditional branch, B immediate
    op_jalr   = 7'b110_0111,  // register indirect jump
    op_jal    = 7'b110_1111   // direct jump, J immediate
  } opcode_e;

  // what the predictor makes of a slot
  typedef enum logic [1:0] {
    kind_plain,   // falls through to pc + 4
    kind_jump,    // always taken
    kind_branch   // taken only when backward
  } inst_kind_e;

endpackage

// ==== logic/fetch_queue.sv ====
// fetch queue that takes bundles of up to two and sends one instruction per cycle to decode on credit
module fetch_queue (
  input  logic                                                         clock,
  input  logic                                                         reset,
  input  logic                                                         flush,
  input  logic                                                         enq,
  input  logic [fetch_pkg::fetch_width-1:0]                            slot_valid,
  input  logic [fetch_pkg::fetch_width-1:0][fetch_pkg::xlen-1:0]       slot_pc,
  input  logic [fetch_pkg::fetch_width-1:0][fetch_pkg::inst_width-1:0] slot_inst,
  input  logic [fetch_pkg::fetch_width-1:0][fetch_pkg::xlen-1:0]       slot_next,
  input  logic                                                         dec_credit,
  output logic                                                         enq_ready,
  output logic                                                         dec_valid,
  output logic [fetch_pkg::xlen-1:0]                                   dec_pc,
  output logic [fetch_pkg::inst_width-1:0]                             dec_inst,
  output logic [fetch_pkg::xlen-1:0]                                   dec_pred_next
);
  import fetch_pkg::*;

  // entry storage
  logic [xlen-1:0]       pc_mem   [queue_depth];
  logic [inst_width-1:0] inst_mem [queue_depth];
  logic [xlen-1:0]       next_mem [queue_depth];

  logic [qptr_width-1:0]     head;        // oldest entry
  logic [qptr_width-1:0]     tail;        // first free entry
  logic [count_width-1:0]    count;       // entries held
  logic [credit_width-1:0]   credit_cnt;  // free slots in decode's buffer

  logic                      accept;      // bundle written this edge
  logic                      send;        // head entry goes out this edge
  logic [slot_cnt_width-1:0] n_valid;     // live slots in the offered bundle
  logic [slot_cnt_width-1:0] n_in;        // entries actually written
  logic [qptr_width-1:0]     wr_idx [fetch_width];

  //////////////////////////////////////////////////////////////////////
  // enqueue side
  //////////////////////////////////////////////////////////////////////

  // room for a full bundle is required even if only one slot is live
  assign enq_ready = count <= count_width'(queue_depth - fetch_width);
  assign accept    = enq && enq_ready && !flush;  // stale bundle dies with the flush

  // live slots pack down in slot order starting at tail
  always_comb
  begin
    n_valid = '0;
    for (int s = 0; s < fetch_width; s++)
    begin
      wr_idx[s] = tail + qptr_width'(n_valid);
      n_valid   = n_valid + slot_cnt_width'(slot_valid[s]);
    end
  end

  assign n_in = accept ? n_valid : '0;

  always_ff @(posedge clock)
  begin
    for (int s = 0; s < fetch_width; s++)
    begin
      if (accept && slot_valid[s])
      begin
        pc_mem[wr_idx[s]]   <= slot_pc[s];
        inst_mem[wr_idx[s]] <= slot_inst[s];
        next_mem[wr_idx[s]] <= slot_next[s];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // decode side
  //////////////////////////////////////////////////////////////////////

  // one per cycle, needs an entry and a credit
  assign send = (count != '0) && (credit_cnt != '0) && !flush;

  // pointers, occupancy and the output flag; a flush empties everything
  always_ff @(posedge clock)
  begin
    if (reset || flush)
    begin
      head      <= '0;
      tail      <= '0;
      count     <= '0;
      dec_valid <= 1'b0;
    end
    else
    begin
      head      <= head + qptr_width'(send);
      tail      <= tail + qptr_width'(n_in);  // wraps at queue_depth
      count     <= count + count_width'(n_in) - count_width'(send);
      dec_valid <= send;
    end
  end

  // output payload follows the head entry
  always_ff @(posedge clock)
  begin
    if (send)
    begin
      dec_pc        <= pc_mem[head];
      dec_inst      <= inst_mem[head];
      dec_pred_next <= next_mem[head];
    end
  end

  // credits track decode's buffer so a flush leaves them alone
  always_ff @(posedge clock)
  begin
    if (reset)
      credit_cnt <= credit_width'(decode_credits);
    else
    begin
      case ({send, dec_credit})
        2'b10:   credit_cnt <= credit_cnt - credit_width'(1);  // spent on a send
        2'b01:   credit_cnt <= credit_cnt + credit_width'(1);  // returned by decode
        default: credit_cnt <= credit_cnt;                     // both or neither
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // decode never returns more than it was given
  a_credit_bound: assert property (@(posedge clock) disable iff (reset)
    credit_cnt <= credit_width'(decode_credits));

  // enq_ready keeps a full bundle from overrunning the buffer
  a_no_overflow: assert property (@(posedge clock) disable iff (reset)
    accept |-> (count + n_valid) <= queue_depth);

  // every delivered instruction was paid for
  a_send_has_credit: assert property (@(posedge clock) disable iff (reset)
    dec_valid |-> $past(credit_cnt) != '0);

endmodule

// ==== logic/fetch_stage.sv ====
// fetch stage holding the pc, splitting each memory word into slots and choosing the next pc
module fetch_stage (
  input  logic                                                         clock,
  input  logic                                                         reset,
  input  logic [fetch_pkg::xlen-1:0]                                   imem_data,
  input  logic                                                         imem_valid,
  input  logic                                                         enq_ready,
  input  logic                                                         redirect_valid,
  input  logic [fetch_pkg::xlen-1:0]                                   redirect_pc,
  input  logic [fetch_pkg::fetch_width-1:0]                            slot_valid,
  input  logic                                                         pred_taken,
  input  logic [fetch_pkg::xlen-1:0]                                   pred_target,
  output logic [fetch_pkg::xlen-1:0]                                   imem_addr,
  output logic [fetch_pkg::fetch_width-1:0][fetch_pkg::xlen-1:0]       slot_pc,
  output logic [fetch_pkg::fetch_width-1:0][fetch_pkg::inst_width-1:0] slot_inst,
  output logic [fetch_pkg::fetch_width-1:0]                            slot_fetched,
  output logic                                                         enq
);
  import fetch_pkg::*;

  logic [xlen-1:0] pc;          // pc of the bundle being fetched
  logic [xlen-1:0] pc_aligned;  // start of the memory word
  logic [xlen-1:0] next_pc;     // value loaded on the next enabled edge
  logic            accept;      // queue takes the bundle this edge
  logic            pc_enable;

  //////////////////////////////////////////////////////////////////////
  // memory address and slot split
  //////////////////////////////////////////////////////////////////////

  assign pc_aligned = {pc[xlen-1:3], 3'b000};
  assign imem_addr  = pc_aligned;  // one aligned 64-bit word per cycle

  // slot 0 is skipped when the pc points at the upper half of the word
  assign slot_fetched[0] = imem_valid && !pc[2];
  assign slot_fetched[1] = imem_valid;

  // lower half is the even word address, upper half the odd one
  always_comb
  begin
    for (int s = 0; s < fetch_width; s++)
    begin
      slot_pc[s] = pc_aligned + xlen'(4 * s);
      if (slot_fetched[s])
        slot_inst[s] = imem_data[s*inst_width +: inst_width];
      else
        slot_inst[s] = nop_inst;  // unfetched slot is harmless to predecode
    end
  end

  // a bundle is offered whenever predecode left any slot alive
  assign enq = |slot_valid;

  //////////////////////////////////////////////////////////////////////
  // next pc
  //////////////////////////////////////////////////////////////////////

  assign accept = enq && enq_ready;

  // redirect must win over a stall or it would be lost
  assign pc_enable = redirect_valid || accept;

  // priority is redirect, then prediction, then sequential
  always_comb
  begin
    if (redirect_valid)
      next_pc = redirect_pc;
    else if (pred_taken)
      next_pc = pred_target;                      // first taken slot
    else
      next_pc = pc_aligned + xlen'(fetch_width * 4);  // next memory word
  end

  always_ff @(posedge clock)
  begin
    if (reset)
      pc <= '0;  // fetch starts at address 0
    else if (pc_enable)
      pc <= next_pc;
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // memory never sees a byte offset
  a_imem_addr_aligned: assert property (@(posedge clock) disable iff (reset)
    imem_addr[2:0] == 3'b000);

  // targets from predecode and execute keep the pc on instruction boundaries
  a_pc_inst_aligned: assert property (@(posedge clock) disable iff (reset)
    pc[1:0] == 2'b00);

endmodule

// ==== logic/fetch_unit.sv ====
// fetch unit top joining the fetch stage, bundle predecoder and fetch queue
module fetch_unit (
  input  logic                             clock,
  input  logic                             reset,
  input  logic [fetch_pkg::xlen-1:0]       imem_data,
  input  logic                             imem_valid,
  input  logic                             redirect_valid,
  input  logic [fetch_pkg::xlen-1:0]       redirect_pc,
  input  logic                             dec_credit,
  output logic [fetch_pkg::xlen-1:0]       imem_addr,
  output logic                             dec_valid,
  output logic [fetch_pkg::xlen-1:0]       dec_pc,
  output logic [fetch_pkg::inst_width-1:0] dec_inst,
  output logic [fetch_pkg::xlen-1:0]       dec_pred_next
);
  import fetch_pkg::*;

  // bundle as fetched
  logic [fetch_width-1:0][xlen-1:0]       slot_pc;
  logic [fetch_width-1:0][inst_width-1:0] slot_inst;
  logic [fetch_width-1:0]                 slot_fetched;

  // predecode results
  logic [fetch_width-1:0]                 slot_valid;
  logic [fetch_width-1:0][xlen-1:0]       slot_next;
  logic                                   pred_taken;
  logic [xlen-1:0]                        pred_target;

  // enqueue handshake
  logic                                   enq;
  logic                                   enq_ready;

  fetch_stage fetch_stage_inst (
    .clock          (clock),
    .reset          (reset),
    .imem_data      (imem_data),
    .imem_valid     (imem_valid),
    .enq_ready      (enq_ready),
    .redirect_valid (redirect_valid),  // pc load
    .redirect_pc    (redirect_pc),
    .slot_valid     (slot_valid),
    .pred_taken     (pred_taken),
    .pred_target    (pred_target),
    .imem_addr      (imem_addr),
    .slot_pc        (slot_pc),
    .slot_inst      (slot_inst),
    .slot_fetched   (slot_fetched),
    .enq            (enq)
  );

  bundle_predecode bundle_predecode_inst (
    .slot_inst    (slot_inst),
    .slot_pc      (slot_pc),
    .slot_fetched (slot_fetched),
    .slot_valid   (slot_valid),
    .slot_next    (slot_next),
    .pred_taken   (pred_taken),
    .pred_target  (pred_target)
  );

  fetch_queue fetch_queue_inst (
    .clock         (clock),
    .reset         (reset),
    .flush         (redirect_valid),  // same redirect empties the queue
    .enq           (enq),
    .slot_valid    (slot_valid),
    .slot_pc       (slot_pc),
    .slot_inst     (slot_inst),
    .slot_next     (slot_next),
    .dec_credit    (dec_credit),
    .enq_ready     (enq_ready),
    .dec_valid     (dec_valid),
    .dec_pc        (dec_pc),
    .dec_inst      (dec_inst),
    .dec_pred_next (dec_pred_next)
  );

endmodule
